//--- flist.f
rtl/rv_isa_pkg.sv
rtl/core_ctrl_pkg.sv
rtl/reg_file.sv
rtl/insn_decoder.sv
rtl/int_alu.sv
rtl/branch_unit.sv
rtl/lsu_align.sv
rtl/rv_core.sv
testbench/tb_clock_gen.sv
testbench/tb_rv_core.sv

//--- rtl/branch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module branch_unit (
  input  rv_isa_pkg::word_t pc,
  input  rv_isa_pkg::word_t rs1_val,
  input  rv_isa_pkg::word_t rs2_val,
  input  rv_isa_pkg::word_t imm,
  input  logic [2:0]        funct3,
  input  logic              is_branch,
  input  logic              is_jal,
  input  logic              is_jalr,
  output rv_isa_pkg::word_t next_pc,
  output rv_isa_pkg::word_t link
);

  logic              taken;
  rv_isa_pkg::word_t pc_target;
  rv_isa_pkg::word_t jalr_target;

  always_comb begin
    case (funct3)
      rv_isa_pkg::f3_beq:  taken = (rs1_val == rs2_val);
      rv_isa_pkg::f3_bne:  taken = (rs1_val != rs2_val);
      rv_isa_pkg::f3_blt:  taken = ($signed(rs1_val) < $signed(rs2_val));
      rv_isa_pkg::f3_bge:  taken = ($signed(rs1_val) >= $signed(rs2_val));
      rv_isa_pkg::f3_bltu: taken = (rs1_val < rs2_val);
      rv_isa_pkg::f3_bgeu: taken = (rs1_val >= rs2_val);
      default:             taken = 1'b0;
    endcase
  end

  assign link      = pc + 32'd4;
  assign pc_target = pc + imm;
  // jalr target drops bit 0
  assign jalr_target = (rs1_val + imm) & ~32'd1;

  always_comb begin
    if (is_jalr) begin
      next_pc = jalr_target;
    end else if (is_jal || (is_branch && taken)) begin
      next_pc = pc_target;
    end else begin
      next_pc = link;
    end
  end

endmodule

`default_nettype wire

//--- rtl/core_ctrl_pkg.sv
`default_nettype none

package core_ctrl_pkg;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_b
  } alu_op_t;

  // source of the register write-back value
  typedef enum logic [1:0] {
    wb_alu,
    wb_load,
    wb_link
  } wb_sel_t;

  typedef enum logic [1:0] {
    mem_none,
    mem_load,
    mem_store
  } mem_op_t;

endpackage

`default_nettype wire

//--- rtl/insn_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module insn_decoder (
  input  rv_isa_pkg::word_t      insn,
  output rv_isa_pkg::reg_idx_t   rs1_idx,
  output rv_isa_pkg::reg_idx_t   rs2_idx,
  output rv_isa_pkg::reg_idx_t   rd_idx,
  output rv_isa_pkg::word_t      imm,
  output core_ctrl_pkg::alu_op_t alu_op,
  output logic                   alu_use_imm,
  output logic                   alu_use_pc,
  output logic                   is_branch,
  output logic                   is_jal,
  output logic                   is_jalr,
  output logic [2:0]             funct3,
  output core_ctrl_pkg::mem_op_t mem_op,
  output core_ctrl_pkg::wb_sel_t wb_sel,
  output logic                   rd_we,
  output logic                   is_ecall
);

  rv_isa_pkg::opcode_t    opcode;
  logic [6:0]             funct7;
  logic                   f7_zero;
  logic                   f7_alt;
  logic                   rr_ok;
  logic                   ri_ok;
  core_ctrl_pkg::alu_op_t arith_op;
  rv_isa_pkg::word_t      imm_i;
  rv_isa_pkg::word_t      imm_s;
  rv_isa_pkg::word_t      imm_b;
  rv_isa_pkg::word_t      imm_j;
  rv_isa_pkg::word_t      imm_u;

  assign opcode  = rv_isa_pkg::opcode_t'(insn[6:0]);
  assign rd_idx  = insn[11:7];
  assign funct3  = insn[14:12];
  assign rs1_idx = insn[19:15];
  assign rs2_idx = insn[24:20];
  assign funct7  = insn[31:25];

  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
  assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
  assign imm_u = {insn[31:12], 12'b0};

  assign f7_zero = (funct7 == 7'b0);
  assign f7_alt  = (funct7 == rv_isa_pkg::funct7_alt);
  // alt funct7 only legal on add/sub and the right shifts
  assign rr_ok = f7_zero || (f7_alt && (funct3 == rv_isa_pkg::f3_add_sub ||
                                        funct3 == rv_isa_pkg::f3_sr));
  // immediate shifts carry funct7 in the top of the immediate
  assign ri_ok = (funct3 == rv_isa_pkg::f3_sll) ? f7_zero :
                 (funct3 == rv_isa_pkg::f3_sr)  ? (f7_zero || f7_alt) : 1'b1;

  assign is_ecall = (opcode == rv_isa_pkg::op_system) && (insn[31:7] == 25'b0);

  always_comb begin
    case (funct3)
      rv_isa_pkg::f3_add_sub: begin
        arith_op = (opcode == rv_isa_pkg::op_reg_reg && f7_alt) ? core_ctrl_pkg::alu_sub
                                                                : core_ctrl_pkg::alu_add;
      end
      rv_isa_pkg::f3_sll:  arith_op = core_ctrl_pkg::alu_sll;
      rv_isa_pkg::f3_slt:  arith_op = core_ctrl_pkg::alu_slt;
      rv_isa_pkg::f3_sltu: arith_op = core_ctrl_pkg::alu_sltu;
      rv_isa_pkg::f3_xor:  arith_op = core_ctrl_pkg::alu_xor;
      rv_isa_pkg::f3_sr:   arith_op = f7_alt ? core_ctrl_pkg::alu_sra : core_ctrl_pkg::alu_srl;
      rv_isa_pkg::f3_or:   arith_op = core_ctrl_pkg::alu_or;
      default:             arith_op = core_ctrl_pkg::alu_and;
    endcase
  end

  always_comb begin
    imm         = imm_i;
    alu_op      = core_ctrl_pkg::alu_add;
    alu_use_imm = 1'b0;
    alu_use_pc  = 1'b0;
    is_branch   = 1'b0;
    is_jal      = 1'b0;
    is_jalr     = 1'b0;
    mem_op      = core_ctrl_pkg::mem_none;
    wb_sel      = core_ctrl_pkg::wb_alu;
    rd_we       = 1'b0;
    case (opcode)
      rv_isa_pkg::op_lui: begin
        imm         = imm_u;
        alu_op      = core_ctrl_pkg::alu_pass_b;
        alu_use_imm = 1'b1;
        rd_we       = 1'b1;
      end
      rv_isa_pkg::op_auipc: begin
        imm         = imm_u;
        alu_use_imm = 1'b1;
        alu_use_pc  = 1'b1;
        rd_we       = 1'b1;
      end
      rv_isa_pkg::op_jal: begin
        imm    = imm_j;
        is_jal = 1'b1;
        wb_sel = core_ctrl_pkg::wb_link;
        rd_we  = 1'b1;
      end
      rv_isa_pkg::op_jalr: begin
        is_jalr = (funct3 == 3'b000);
        wb_sel  = core_ctrl_pkg::wb_link;
        rd_we   = (funct3 == 3'b000);
      end
      rv_isa_pkg::op_branch: begin
        imm = imm_b;
        // funct3 010 and 011 are reserved
        is_branch = (funct3[2:1] != 2'b01);
      end
      rv_isa_pkg::op_load: begin
        alu_use_imm = 1'b1;
        if (funct3 inside {rv_isa_pkg::f3_byte, rv_isa_pkg::f3_half, rv_isa_pkg::f3_word,
                           rv_isa_pkg::f3_byte_u, rv_isa_pkg::f3_half_u}) begin
          mem_op = core_ctrl_pkg::mem_load;
          wb_sel = core_ctrl_pkg::wb_load;
          rd_we  = 1'b1;
        end
      end
      rv_isa_pkg::op_store: begin
        imm         = imm_s;
        alu_use_imm = 1'b1;
        if (funct3 inside {rv_isa_pkg::f3_byte, rv_isa_pkg::f3_half, rv_isa_pkg::f3_word}) begin
          mem_op = core_ctrl_pkg::mem_store;
        end
      end
      rv_isa_pkg::op_reg_imm: begin
        alu_op      = arith_op;
        alu_use_imm = 1'b1;
        rd_we       = ri_ok;
      end
      rv_isa_pkg::op_reg_reg: begin
        alu_op = arith_op;
        rd_we  = rr_ok;
      end
      // fence retires as a no-op
      rv_isa_pkg::op_misc_mem: ;
      default: ;
    endcase
  end

endmodule

`default_nettype wire

//--- rtl/int_alu.sv
`timescale 1ns/1ps
`default_nettype none

module int_alu (
  input  rv_isa_pkg::word_t      a,
  input  rv_isa_pkg::word_t      b,
  input  core_ctrl_pkg::alu_op_t op,
  output rv_isa_pkg::word_t      result
);

  logic [4:0] shamt;

  // only the low five bits shift
  assign shamt = b[4:0];

  always_comb begin
    case (op)
      core_ctrl_pkg::alu_add: begin
        result = a + b;
      end
      core_ctrl_pkg::alu_sub: begin
        result = a - b;
      end
      core_ctrl_pkg::alu_sll: begin
        result = a << shamt;
      end
      core_ctrl_pkg::alu_slt: begin
        result = {31'b0, $signed(a) < $signed(b)};
      end
      core_ctrl_pkg::alu_sltu: begin
        result = {31'b0, a < b};
      end
      core_ctrl_pkg::alu_xor: begin
        result = a ^ b;
      end
      core_ctrl_pkg::alu_srl: begin
        result = a >> shamt;
      end
      core_ctrl_pkg::alu_sra: begin
        result = $signed(a) >>> shamt;
      end
      core_ctrl_pkg::alu_or: begin
        result = a | b;
      end
      core_ctrl_pkg::alu_and: begin
        result = a & b;
      end
      // lui passes the u-immediate through
      core_ctrl_pkg::alu_pass_b: begin
        result = b;
      end
      default: begin
        result = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- rtl/lsu_align.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_align (
  input  rv_isa_pkg::word_t      eff_addr,
  input  core_ctrl_pkg::mem_op_t mem_op,
  input  logic [2:0]             funct3,
  input  rv_isa_pkg::word_t      rs2_val,
  input  rv_isa_pkg::word_t      load_data,
  output rv_isa_pkg::word_t      dmem_addr,
  output rv_isa_pkg::word_t      store_data,
  output rv_isa_pkg::strobe_t    store_strobe,
  output rv_isa_pkg::word_t      load_val
);

  logic [1:0]          offset;
  logic [7:0]          load_byte;
  logic [15:0]         load_half;
  rv_isa_pkg::strobe_t size_mask;

  assign offset    = eff_addr[1:0];
  assign dmem_addr = {eff_addr[31:2], 2'b00};

  // store data is replicated, the strobe picks the lanes
  always_comb begin
    case (funct3)
      rv_isa_pkg::f3_byte: begin
        store_data = {4{rs2_val[7:0]}};
        size_mask  = 4'b0001 << offset;
      end
      rv_isa_pkg::f3_half: begin
        store_data = {2{rs2_val[15:0]}};
        size_mask  = offset[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        store_data = rs2_val;
        size_mask  = 4'b1111;
      end
    endcase
  end

  assign store_strobe = (mem_op == core_ctrl_pkg::mem_store) ? size_mask : 4'b0000;

  // addressed byte and halfword of the loaded word
  assign load_byte = load_data[8*offset +: 8];
  assign load_half = offset[1] ? load_data[31:16] : load_data[15:0];

  always_comb begin
    case (funct3)
      rv_isa_pkg::f3_byte:   load_val = {{24{load_byte[7]}}, load_byte};
      rv_isa_pkg::f3_half:   load_val = {{16{load_half[15]}}, load_half};
      rv_isa_pkg::f3_byte_u: load_val = {24'b0, load_byte};
      rv_isa_pkg::f3_half_u: load_val = {16'b0, load_half};
      rv_isa_pkg::f3_word:   load_val = load_data;
      default:               load_val = load_data;
    endcase
  end

endmodule

`default_nettype wire

//--- rtl/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file #(
  parameter int num_regs = 32
) (
  input  logic                 clk,
  input  logic                 rst,
  input  rv_isa_pkg::reg_idx_t rs1_idx,
  input  rv_isa_pkg::reg_idx_t rs2_idx,
  input  rv_isa_pkg::reg_idx_t rd_idx,
  input  rv_isa_pkg::word_t    rd_val,
  input  logic                 rd_we,
  output rv_isa_pkg::word_t    rs1_val,
  output rv_isa_pkg::word_t    rs2_val
);

  rv_isa_pkg::word_t regs [num_regs];

  // x0 is never written, so it reads zero after reset
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (rd_we && rd_idx != '0 && rd_idx < num_regs) begin
      regs[rd_idx] <= rd_val;
    end
  end

  // indices past the top (rv32e) read as zero
  assign rs1_val = (rs1_idx < num_regs) ? regs[rs1_idx] : '0;
  assign rs2_val = (rs2_idx < num_regs) ? regs[rs2_idx] : '0;

endmodule

`default_nettype wire

//--- rtl/rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core #(
  parameter int num_regs = 32
) (
  input  logic                clk,
  input  logic                rst,
  input  rv_isa_pkg::word_t   insn,
  input  rv_isa_pkg::word_t   load_data,
  output rv_isa_pkg::word_t   pc,
  output rv_isa_pkg::word_t   dmem_addr,
  output rv_isa_pkg::word_t   store_data,
  output rv_isa_pkg::strobe_t store_strobe,
  output logic                halt
);

  rv_isa_pkg::reg_idx_t   rs1_idx;
  rv_isa_pkg::reg_idx_t   rs2_idx;
  rv_isa_pkg::reg_idx_t   rd_idx;
  rv_isa_pkg::word_t      imm;
  rv_isa_pkg::word_t      rs1_val;
  rv_isa_pkg::word_t      rs2_val;
  rv_isa_pkg::word_t      alu_a;
  rv_isa_pkg::word_t      alu_b;
  rv_isa_pkg::word_t      alu_result;
  rv_isa_pkg::word_t      load_val;
  rv_isa_pkg::word_t      link;
  rv_isa_pkg::word_t      next_pc;
  rv_isa_pkg::word_t      rd_val;
  rv_isa_pkg::strobe_t    raw_strobe;
  core_ctrl_pkg::alu_op_t alu_op;
  core_ctrl_pkg::mem_op_t mem_op;
  core_ctrl_pkg::wb_sel_t wb_sel;
  logic [2:0]             funct3;
  logic                   alu_use_imm;
  logic                   alu_use_pc;
  logic                   is_branch;
  logic                   is_jal;
  logic                   is_jalr;
  logic                   dec_rd_we;
  logic                   is_ecall;
  logic                   retire;

  insn_decoder u_decoder (
    .insn        (insn),
    .rs1_idx     (rs1_idx),
    .rs2_idx     (rs2_idx),
    .rd_idx      (rd_idx),
    .imm         (imm),
    .alu_op      (alu_op),
    .alu_use_imm (alu_use_imm),
    .alu_use_pc  (alu_use_pc),
    .is_branch   (is_branch),
    .is_jal      (is_jal),
    .is_jalr     (is_jalr),
    .funct3      (funct3),
    .mem_op      (mem_op),
    .wb_sel      (wb_sel),
    .rd_we       (dec_rd_we),
    .is_ecall    (is_ecall)
  );

  reg_file #(
    .num_regs (num_regs)
  ) u_reg_file (
    .clk     (clk),
    .rst     (rst),
    .rs1_idx (rs1_idx),
    .rs2_idx (rs2_idx),
    .rd_idx  (rd_idx),
    .rd_val  (rd_val),
    .rd_we   (dec_rd_we && retire),
    .rs1_val (rs1_val),
    .rs2_val (rs2_val)
  );

  assign alu_a = alu_use_pc ? pc : rs1_val;
  assign alu_b = alu_use_imm ? imm : rs2_val;

  int_alu u_alu (
    .a      (alu_a),
    .b      (alu_b),
    .op     (alu_op),
    .result (alu_result)
  );

  branch_unit u_branch (
    .pc        (pc),
    .rs1_val   (rs1_val),
    .rs2_val   (rs2_val),
    .imm       (imm),
    .funct3    (funct3),
    .is_branch (is_branch),
    .is_jal    (is_jal),
    .is_jalr   (is_jalr),
    .next_pc   (next_pc),
    .link      (link)
  );

  // loads and stores address through the alu sum
  lsu_align u_lsu (
    .eff_addr     (alu_result),
    .mem_op       (mem_op),
    .funct3       (funct3),
    .rs2_val      (rs2_val),
    .load_data    (load_data),
    .dmem_addr    (dmem_addr),
    .store_data   (store_data),
    .store_strobe (raw_strobe),
    .load_val     (load_val)
  );

  assign halt   = !rst && is_ecall;
  // nothing commits in reset or once ecall is reached
  assign retire = !rst && !is_ecall;

  assign store_strobe = retire ? raw_strobe : 4'b0000;

  always_comb begin
    case (wb_sel)
      core_ctrl_pkg::wb_load: rd_val = load_val;
      core_ctrl_pkg::wb_link: rd_val = link;
      default:                rd_val = alu_result;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
    end else if (!halt) begin
      pc <= next_pc;
    end
  end

endmodule

`default_nettype wire

//--- rtl/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

  localparam int xlen = 32;

  typedef logic [xlen-1:0] word_t;
  typedef logic [4:0] reg_idx_t;
  // one bit per byte lane, bit 0 is the least significant byte
  typedef logic [3:0] strobe_t;

  // major opcodes, insn[6:0]
  typedef enum logic [6:0] {
    op_load     = 7'b0000011,
    op_misc_mem = 7'b0001111,
    op_reg_imm  = 7'b0010011,
    op_auipc    = 7'b0010111,
    op_store    = 7'b0100011,
    op_reg_reg  = 7'b0110011,
    op_lui      = 7'b0110111,
    op_branch   = 7'b1100011,
    op_jalr     = 7'b1100111,
    op_jal      = 7'b1101111,
    op_system   = 7'b1110011
  } opcode_t;

  // alu minor ops
  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_sll     = 3'b001;
  localparam logic [2:0] f3_slt     = 3'b010;
  localparam logic [2:0] f3_sltu    = 3'b011;
  localparam logic [2:0] f3_xor     = 3'b100;
  localparam logic [2:0] f3_sr      = 3'b101;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_and     = 3'b111;

  // branch conditions
  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  // load and store sizes
  localparam logic [2:0] f3_byte   = 3'b000;
  localparam logic [2:0] f3_half   = 3'b001;
  localparam logic [2:0] f3_word   = 3'b010;
  localparam logic [2:0] f3_byte_u = 3'b100;
  localparam logic [2:0] f3_half_u = 3'b101;

  // selects sub and sra
  localparam logic [6:0] funct7_alt = 7'b0100000;

endpackage

`default_nettype wire

//--- run.sh
#!/bin/sh
# compile and run the rv_core testbench with verilator

verilator --binary --timing -Wno-fatal -f flist.f --top-module tb_rv_core --Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

./obj_dir/Vtb_rv_core > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "Test FAILED" sim.log; then
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi
exit 0

//--- testbench/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic clk,
  output logic rst
);

  localparam int half_period  = 10;
  localparam int reset_cycles = 8;

  initial begin
    clk = 1'b0;
    forever #half_period clk = ~clk;
  end

  // reset drops shortly after the last reset edge
  initial begin
    rst = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    #2;
    rst = 1'b0;
  end

endmodule

`default_nettype wire

//--- testbench/tb_rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;

  localparam int prog_len      = 200;
  // dump stores start here, random body ends just before
  localparam int body_end      = prog_len - 32;
  localparam int timeout_limit = 4 * prog_len + 64;
  localparam rv_isa_pkg::word_t ecall_word = 32'h0000_0073;

  logic                clk;
  logic                rst;
  rv_isa_pkg::word_t   insn;
  rv_isa_pkg::word_t   load_data;
  rv_isa_pkg::word_t   pc;
  rv_isa_pkg::word_t   dmem_addr;
  rv_isa_pkg::word_t   store_data;
  rv_isa_pkg::strobe_t store_strobe;
  logic                halt;

  rv_isa_pkg::word_t imem [256];
  rv_isa_pkg::word_t dmem [256];
  // reference model state
  rv_isa_pkg::word_t mmem [256];
  rv_isa_pkg::word_t mregs [32];
  rv_isa_pkg::word_t mpc;
  rv_isa_pkg::word_t lfsr_state;
  int                cycle_count = 0;

  tb_clock_gen u_clock_gen (
    .clk (clk),
    .rst (rst)
  );

  rv_core #(
    .num_regs (32)
  ) DUT (
    .clk          (clk),
    .rst          (rst),
    .insn         (insn),
    .load_data    (load_data),
    .pc           (pc),
    .dmem_addr    (dmem_addr),
    .store_data   (store_data),
    .store_strobe (store_strobe),
    .halt         (halt)
  );

  // both memories read combinationally
  assign insn      = imem[pc[9:2]];
  assign load_data = dmem[dmem_addr[9:2]];

  function automatic rv_isa_pkg::word_t fill_word(input int i);
    return (rv_isa_pkg::word_t'(i) * 32'h0101_0101) ^ 32'h5a3c_c3a5;
  endfunction

  always @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 256; i++) begin
        dmem[i] <= fill_word(i);
      end
    end else begin
      for (int i = 0; i < 4; i++) begin
        if (store_strobe[i]) begin
          dmem[dmem_addr[9:2]][8*i +: 8] <= store_data[8*i +: 8];
        end
      end
    end
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test FAILED");
    $fatal(1, "simulation stopped");
  endtask

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > timeout_limit) begin
      abort_run($sformatf("timeout: halt never arrived within %0d cycles", timeout_limit));
    end
  end

  task automatic check_word(input string name, input rv_isa_pkg::word_t expected,
                            input rv_isa_pkg::word_t actual);
    if (actual !== expected) begin
      abort_run($sformatf("error: %s expected %h actual %h", name, expected, actual));
    end
  endtask

  task automatic check_strobe(input string name, input rv_isa_pkg::strobe_t expected,
                              input rv_isa_pkg::strobe_t actual);
    if (actual !== expected) begin
      abort_run($sformatf("error: %s expected %b actual %b", name, expected, actual));
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      abort_run($sformatf("error: %s expected %b actual %b", name, expected, actual));
    end
  endtask

  function automatic rv_isa_pkg::word_t lfsr_next(input rv_isa_pkg::word_t s);
    return s[0] ? ((s >> 1) ^ 32'hb4bc_d35c) : (s >> 1);
  endfunction

  // one lfsr step per bit taken
  function automatic rv_isa_pkg::word_t rand_bits(input int n);
    rv_isa_pkg::word_t v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
    return v;
  endfunction

  function automatic logic [4:0] rand_reg();
    rv_isa_pkg::word_t v;
    v = rand_bits(5);
    return v[4:0];
  endfunction

  function automatic rv_isa_pkg::word_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                              input logic [2:0] f3, input logic [4:0] rd,
                                              input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic rv_isa_pkg::word_t enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                              input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], rv_isa_pkg::op_store};
  endfunction

  function automatic rv_isa_pkg::word_t enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                              input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_isa_pkg::op_branch};
  endfunction

  function automatic rv_isa_pkg::word_t enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_isa_pkg::op_jal};
  endfunction

  // x31 is the data base and never a random destination
  task automatic build_program();
    rv_isa_pkg::word_t r;
    rv_isa_pkg::word_t imm;
    logic [4:0]        rd;
    logic [4:0]        rs1;
    logic [4:0]        rs2;
    logic [2:0]        f3;
    logic [6:0]        f7;
    int                k;
    for (int i = 0; i < 256; i++) begin
      imem[i] = enc_i(i[11:0], 5'd0, 3'b000, 5'd0, rv_isa_pkg::op_reg_imm);
    end
    // a store sits at the reset pc, its strobe stays low while in reset
    imem[0] = enc_s(12'd0, 5'd0, 5'd0, 3'b010);
    imem[1] = {20'h0, 5'd31, rv_isa_pkg::op_lui};
    imem[2] = enc_i(12'd512, 5'd31, 3'b000, 5'd31, rv_isa_pkg::op_reg_imm);
    for (int idx = 3; idx < body_end; idx++) begin
      rd = rand_reg();
      if (rd == 5'd31) begin
        rd = 5'd0;
      end
      rs1 = rand_reg();
      rs2 = rand_reg();
      r = rand_bits(3);
      f3 = r[2:0];
      // forward distance for jumps and branches
      r = rand_bits(3);
      k = 1 + int'(r[2:0]);
      if (k > body_end - idx) begin
        k = body_end - idx;
      end
      r = rand_bits(4);
      case (r[3:0])
        4'd0, 4'd1, 4'd2: begin
          r = rand_bits(1);
          f7 = ((f3 == 3'b000 || f3 == 3'b101) && r[0]) ? rv_isa_pkg::funct7_alt : 7'b0;
          imem[idx] = {f7, rs2, rs1, f3, rd, rv_isa_pkg::op_reg_reg};
        end
        4'd3, 4'd4, 4'd5: begin
          imm = rand_bits(12);
          r = rand_bits(1);
          if (f3 == 3'b001) begin
            imm[11:5] = 7'b0;
          end else if (f3 == 3'b101) begin
            imm[11:5] = r[0] ? rv_isa_pkg::funct7_alt : 7'b0;
          end
          imem[idx] = enc_i(imm[11:0], rs1, f3, rd, rv_isa_pkg::op_reg_imm);
        end
        4'd6: begin
          imm = rand_bits(20);
          imem[idx] = {imm[19:0], rd, rv_isa_pkg::op_lui};
        end
        4'd7: begin
          imm = rand_bits(20);
          imem[idx] = {imm[19:0], rd, rv_isa_pkg::op_auipc};
        end
        4'd8: begin
          imm = k * 4;
          imem[idx] = enc_j(imm[20:0], rd);
        end
        4'd9: begin
          // absolute target through x0, bit 0 set at random
          imm = (idx + k) * 4;
          r = rand_bits(1);
          imm[0] = r[0];
          imem[idx] = enc_i(imm[11:0], 5'd0, 3'b000, rd, rv_isa_pkg::op_jalr);
        end
        4'd10, 4'd11: begin
          if (f3[2:1] == 2'b01) begin
            f3 = {1'b1, f3[0]};
          end
          r = rand_bits(2);
          if (r[1:0] == 2'b00) begin
            rs2 = rs1;
          end
          imm = k * 4;
          imem[idx] = enc_b(imm[12:0], rs2, rs1, f3);
        end
        4'd12, 4'd13: begin
          if (f3 == 3'b011) begin
            f3 = 3'b010;
          end else if (f3[2:1] == 2'b11) begin
            f3 = {2'b10, f3[0]};
          end
          r = rand_bits(9);
          imm = {{23{r[8]}}, r[8:0]};
          if (f3[1:0] == 2'b01) begin
            imm[0] = 1'b0;
          end else if (f3 == 3'b010) begin
            imm[1:0] = 2'b00;
          end
          imem[idx] = enc_i(imm[11:0], 5'd31, f3, rd, rv_isa_pkg::op_load);
        end
        default: begin
          r = rand_bits(3);
          f3 = (r[1:0] == 2'b11) ? 3'b010 : {1'b0, r[1:0]};
          imm = rand_bits(9);
          imm = {{23{imm[8]}}, imm[8:0]};
          if (f3 == 3'b001) begin
            imm[0] = 1'b0;
          end else if (f3 == 3'b010) begin
            imm[1:0] = 2'b00;
          end
          imem[idx] = enc_s(imm[11:0], rs2, 5'd31, f3);
          // now and then a fence or an unknown opcode instead
          if (r[2] && r[1:0] == 2'b00) begin
            imem[idx] = 32'h0ff0_000f;
          end else if (r[2] && rd == 5'd7) begin
            imem[idx] = {imm[24:0], 7'b1111011};
          end
        end
      endcase
    end
    for (int j = 1; j < 32; j++) begin
      imm = j * 4;
      imem[body_end - 1 + j] = enc_s(imm[11:0], j[4:0], 5'd0, 3'b010);
    end
    imem[prog_len - 1] = ecall_word;
  endtask

  function automatic rv_isa_pkg::word_t alu_model(input logic [2:0] f3, input logic alt,
                                                  input rv_isa_pkg::word_t a,
                                                  input rv_isa_pkg::word_t b);
    rv_isa_pkg::word_t res;
    case (f3)
      3'b000: res = alt ? a - b : a + b;
      3'b001: res = a << b[4:0];
      3'b010: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011: res = (a < b) ? 32'd1 : 32'd0;
      3'b100: res = a ^ b;
      3'b101: begin
        if (alt) begin
          res = $signed(a) >>> b[4:0];
        end else begin
          res = a >> b[4:0];
        end
      end
      3'b110: res = a | b;
      default: res = a & b;
    endcase
    return res;
  endfunction

  function automatic logic branch_taken(input logic [2:0] f3, input rv_isa_pkg::word_t a,
                                        input rv_isa_pkg::word_t b);
    case (f3)
      3'b000: return a == b;
      3'b001: return a != b;
      3'b100: return $signed(a) < $signed(b);
      3'b101: return $signed(a) >= $signed(b);
      3'b110: return a < b;
      3'b111: return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  function automatic rv_isa_pkg::word_t load_extract(input logic [2:0] f3,
                                                     input rv_isa_pkg::word_t w,
                                                     input logic [1:0] off);
    rv_isa_pkg::word_t shifted;
    shifted = w >> (8 * off);
    case (f3)
      3'b000: return {{24{shifted[7]}}, shifted[7:0]};
      3'b001: return {{16{shifted[15]}}, shifted[15:0]};
      3'b100: return {24'b0, shifted[7:0]};
      3'b101: return {16'b0, shifted[15:0]};
      default: return w;
    endcase
  endfunction

  // executes one instruction and reports the store it makes
  task automatic model_step(output rv_isa_pkg::strobe_t st, output rv_isa_pkg::word_t sa,
                            output rv_isa_pkg::word_t sd);
    rv_isa_pkg::word_t ins;
    rv_isa_pkg::word_t a;
    rv_isa_pkg::word_t b;
    rv_isa_pkg::word_t imm_i;
    rv_isa_pkg::word_t imm_u;
    rv_isa_pkg::word_t ea;
    rv_isa_pkg::word_t res;
    rv_isa_pkg::word_t next_pc;
    logic [2:0]        f3;
    logic              wr;
    ins = imem[mpc[9:2]];
    f3 = ins[14:12];
    a = mregs[ins[19:15]];
    b = mregs[ins[24:20]];
    imm_i = {{20{ins[31]}}, ins[31:20]};
    imm_u = {ins[31:12], 12'b0};
    ea = a + imm_i;
    next_pc = mpc + 32'd4;
    res = '0;
    wr = 1'b0;
    st = '0;
    sa = '0;
    sd = '0;
    case (ins[6:0])
      rv_isa_pkg::op_lui: begin
        res = imm_u;
        wr = 1'b1;
      end
      rv_isa_pkg::op_auipc: begin
        res = mpc + imm_u;
        wr = 1'b1;
      end
      rv_isa_pkg::op_jal: begin
        res = mpc + 32'd4;
        wr = 1'b1;
        next_pc = mpc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
      end
      rv_isa_pkg::op_jalr: begin
        res = mpc + 32'd4;
        wr = 1'b1;
        next_pc = ea & 32'hffff_fffe;
      end
      rv_isa_pkg::op_branch: begin
        if (branch_taken(f3, a, b)) begin
          next_pc = mpc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        end
      end
      rv_isa_pkg::op_load: begin
        res = load_extract(f3, mmem[ea[9:2]], ea[1:0]);
        wr = 1'b1;
      end
      rv_isa_pkg::op_store: begin
        ea = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
        sa = {ea[31:2], 2'b00};
        if (f3 == 3'b000) begin
          st[ea[1:0]] = 1'b1;
          sd = {4{b[7:0]}};
        end else if (f3 == 3'b001) begin
          st[ea[1:0]] = 1'b1;
          st[ea[1:0] + 2'd1] = 1'b1;
          sd = {2{b[15:0]}};
        end else begin
          st = 4'b1111;
          sd = b;
        end
        for (int i = 0; i < 4; i++) begin
          if (st[i]) begin
            mmem[ea[9:2]][8*i +: 8] = sd[8*i +: 8];
          end
        end
      end
      rv_isa_pkg::op_reg_imm: begin
        res = alu_model(f3, (f3 == 3'b101) && ins[30], a, imm_i);
        wr = 1'b1;
      end
      rv_isa_pkg::op_reg_reg: begin
        res = alu_model(f3, ins[30], a, b);
        wr = 1'b1;
      end
      default: ;
    endcase
    if (wr && ins[11:7] != 5'd0) begin
      mregs[ins[11:7]] = res;
    end
    mpc = next_pc;
  endtask

  initial begin
    rv_isa_pkg::strobe_t exp_strobe;
    rv_isa_pkg::word_t   exp_addr;
    rv_isa_pkg::word_t   exp_data;
    logic                at_ecall;
    lfsr_state = 32'h6af8;
    build_program();
    for (int i = 0; i < 32; i++) begin
      mregs[i] = '0;
    end
    for (int i = 0; i < 256; i++) begin
      mmem[i] = fill_word(i);
    end
    mpc = '0;
    at_ecall = 1'b0;

    @(negedge clk);
    while (rst) begin
      check_strobe("reset strobe", 4'b0000, store_strobe);
      check_word("reset pc", 32'h0, pc);
      @(negedge clk);
    end

    // one retired instruction per cycle until ecall
    while (!at_ecall) begin
      check_word("pc", mpc, pc);
      at_ecall = (imem[mpc[9:2]] == ecall_word);
      check_bit("halt", at_ecall, halt);
      if (!at_ecall) begin
        model_step(exp_strobe, exp_addr, exp_data);
        check_strobe("store strobe", exp_strobe, store_strobe);
        if (exp_strobe != 4'b0000) begin
          check_word("store address", exp_addr, dmem_addr);
          check_word("store data", exp_data, store_data);
        end
        @(negedge clk);
      end
    end

    repeat (4) begin
      @(negedge clk);
      check_word("halted pc", mpc, pc);
      check_bit("halt held", 1'b1, halt);
      check_strobe("halted strobe", 4'b0000, store_strobe);
    end

    // register dump and random stores end up in data memory
    for (int i = 0; i < 256; i++) begin
      check_word($sformatf("data word %0d", i), mmem[i], dmem[i]);
    end

    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire
